// ==== include/gambit_cfg.svh ====
/* gambit execute path configuration
   widths of the datapath, the issue queue and the AXI4-Lite host port */
`ifndef GAMBIT_CFG_SVH
`define GAMBIT_CFG_SVH

// width of every operand, immediate and result
`define GAMBIT_WID 52

// issue queue depth, any power of two
`define GAMBIT_QDEPTH 4

// AXI4-Lite address and data widths
`define GAMBIT_AXI_AW 8
`define GAMBIT_AXI_DW 64

`endif

// ==== rtl/gambitIsaPkg.sv ====
/* gambit ISA definitions
   opcode encoding and instruction word layout seen by the ALU */
`include "gambit_cfg.svh"

package gambitIsaPkg;

  // ==============================
  // opcodes
  // ==============================
  // each register-register form takes the immediate in place of B when
  // the zero flag of the instruction word is set
  typedef enum logic [5:0] {
    ADD_RR  = 6'h04,
    SUB_RR  = 6'h05,
    CMP_RR  = 6'h06,
    CMPU_RR = 6'h07,
    AND_RR  = 6'h08,
    OR_RR   = 6'h09,
    EOR_RR  = 6'h0A,
    ASL_RR  = 6'h0C,
    ASR_RR  = 6'h0D,
    LSR_RR  = 6'h0E,
    ROL_RR  = 6'h10,
    ROR_RR  = 6'h11,
    // immediate forms always use the immediate as the second operand
    ADD_RI  = 6'h14,
    SUB_RI  = 6'h15,
    CMP_RI  = 6'h16,
    CMPU_RI = 6'h17,
    AND_RI  = 6'h18,
    OR_RI   = 6'h19,
    EOR_RI  = 6'h1A,
    CSR     = 6'h20
  } opcodeT;

  // ==============================
  // instruction word
  // ==============================
  // opcode in bits 5:0, zero flag in bit 6, upper bits carried but ignored
  typedef struct packed {
    logic [11:0] rsvd;
    logic        zero;
    opcodeT      opcode;
  } instrT;

  // returned for any code not listed above
  localparam logic [`GAMBIT_WID-1:0] ILLEGAL_RESULT = `GAMBIT_WID'h0DEAEDEAEDEAE;

endpackage

// ==== rtl/gambitExecPkg.sv ====
/* gambit execute path types
   issue entry carried through the queue and the AXI response codes */
`include "gambit_cfg.svh"

package gambitExecPkg;

  // one issued operation, 19 + 3 * 52 = 175 bits
  typedef struct packed {
    gambitIsaPkg::instrT     instr;
    logic [`GAMBIT_WID-1:0]  a;
    logic [`GAMBIT_WID-1:0]  b;
    logic [`GAMBIT_WID-1:0]  imm;
  } issueEntryT;

  // AXI response codes, only the two used here
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } respT;

endpackage

// ==== rtl/gambitAlu.sv ====
/* gambit integer ALU
   evaluates one issued operation combinationally on 52-bit operands */
`timescale 1ns/1ps
`include "gambit_cfg.svh"

module gambitAlu (
  input  gambitIsaPkg::instrT     instr,
  input  logic [`GAMBIT_WID-1:0]  a,
  input  logic [`GAMBIT_WID-1:0]  b,
  input  logic [`GAMBIT_WID-1:0]  imm,
  input  logic [`GAMBIT_WID-1:0]  csrValue,
  output logic [`GAMBIT_WID-1:0]  result
);

  // second operand of the register-register forms
  logic [`GAMBIT_WID-1:0] opB;
  // shift amount and the rotate amount folded into 0..51
  logic [5:0]             shAmt;
  logic [5:0]             rotAmt;
  logic [`GAMBIT_WID-1:0] asrRes;
  logic [`GAMBIT_WID-1:0] rolRes;
  logic [`GAMBIT_WID-1:0] rorRes;

  // compare result encoding: 3 less than, 0 equal, 1 greater than
  function automatic logic [`GAMBIT_WID-1:0] cmpRes(input logic lt, input logic eq);
    if (lt)
      return `GAMBIT_WID'd3;
    else if (eq)
      return `GAMBIT_WID'd0;
    return `GAMBIT_WID'd1;
  endfunction

  assign opB    = instr.zero ? imm : b;
  assign shAmt  = opB[5:0];
  assign rotAmt = 6'(shAmt % `GAMBIT_WID);

  // a shift by 52 or more leaves only sign bits, which >>> gives directly
  assign asrRes = $signed(a) >>> shAmt;

  // with rotAmt of 0 the right-hand term shifts everything out
  assign rolRes = (a << rotAmt) | (a >> (`GAMBIT_WID - rotAmt));
  assign rorRes = (a >> rotAmt) | (a << (`GAMBIT_WID - rotAmt));

  // ==============================
  // opcode evaluation
  // ==============================
  always_comb begin
    case (instr.opcode)
      gambitIsaPkg::ADD_RR:  result = a + opB;
      gambitIsaPkg::SUB_RR:  result = a - opB;
      gambitIsaPkg::AND_RR:  result = a & opB;
      gambitIsaPkg::OR_RR:   result = a | opB;
      gambitIsaPkg::EOR_RR:  result = a ^ opB;
      gambitIsaPkg::CMP_RR:  result = cmpRes($signed(a) < $signed(opB), a == opB);
      gambitIsaPkg::CMPU_RR: result = cmpRes(a < opB, a == opB);
      // left and logical right shifts naturally give 0 past 51
      gambitIsaPkg::ASL_RR:  result = a << shAmt;
      gambitIsaPkg::ASR_RR:  result = asrRes;
      gambitIsaPkg::LSR_RR:  result = a >> shAmt;
      gambitIsaPkg::ROL_RR:  result = rolRes;
      gambitIsaPkg::ROR_RR:  result = rorRes;
      // immediate forms, subtract is A minus the immediate
      gambitIsaPkg::ADD_RI:  result = a + imm;
      gambitIsaPkg::SUB_RI:  result = a - imm;
      gambitIsaPkg::AND_RI:  result = a & imm;
      gambitIsaPkg::OR_RI:   result = a | imm;
      gambitIsaPkg::EOR_RI:  result = a ^ imm;
      gambitIsaPkg::CMP_RI:  result = cmpRes($signed(a) < $signed(imm), a == imm);
      gambitIsaPkg::CMPU_RI: result = cmpRes(a < imm, a == imm);
      gambitIsaPkg::CSR:     result = csrValue;
      default:               result = gambitIsaPkg::ILLEGAL_RESULT;
    endcase
  end

endmodule

// ==== rtl/gambitIssue.sv ====
/* gambit issue stage
   AXI4-Lite write slave that stages operands and pushes issue entries */
`timescale 1ns/1ps
`include "gambit_cfg.svh"

module gambitIssue (
  input  logic                        clk,
  input  logic                        arstN,
  input  logic                        awValid,
  input  logic [`GAMBIT_AXI_AW-1:0]   awAddr,
  input  logic                        wValid,
  input  logic [`GAMBIT_AXI_DW-1:0]   wData,
  input  logic                        bReady,
  input  logic                        pushReady,
  output logic                        awReady,
  output logic                        wReady,
  output logic                        bValid,
  output gambitExecPkg::respT         bResp,
  output logic                        pushValid,
  output gambitExecPkg::issueEntryT   pushEntry
);

  // register map of the write channel
  localparam logic [`GAMBIT_AXI_AW-1:0] ADDR_A     = 'h00;
  localparam logic [`GAMBIT_AXI_AW-1:0] ADDR_B     = 'h08;
  localparam logic [`GAMBIT_AXI_AW-1:0] ADDR_IMM   = 'h10;
  localparam logic [`GAMBIT_AXI_AW-1:0] ADDR_INSTR = 'h18;

  localparam int INSTR_W = $bits(gambitIsaPkg::instrT);

  logic                   accept;
  logic [`GAMBIT_WID-1:0] stageA;
  logic [`GAMBIT_WID-1:0] stageB;
  logic [`GAMBIT_WID-1:0] stageImm;

  // address and data are taken together, and only while nothing is pending
  // and the queue could take the entry an instruction write would create
  assign awReady = awValid & wValid & ~bValid & ~pushValid & pushReady;
  assign wReady  = awReady;
  assign accept  = awReady;

  // ==============================
  // staging registers
  // ==============================
  always_ff @(posedge clk) begin
    if (accept && awAddr == ADDR_A)
      stageA <= wData[`GAMBIT_WID-1:0];
    if (accept && awAddr == ADDR_B)
      stageB <= wData[`GAMBIT_WID-1:0];
    if (accept && awAddr == ADDR_IMM)
      stageImm <= wData[`GAMBIT_WID-1:0];
  end

  // the entry snapshots the staged operands at the instruction write
  always_ff @(posedge clk) begin
    if (accept && awAddr == ADDR_INSTR) begin
      pushEntry.instr <= wData[INSTR_W-1:0];
      pushEntry.a     <= stageA;
      pushEntry.b     <= stageB;
      pushEntry.imm   <= stageImm;
    end
  end

  // ==============================
  // push and write response
  // ==============================
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pushValid <= 1'b0;
      bValid    <= 1'b0;
      bResp     <= gambitExecPkg::OKAY;
    end else begin
      if (accept) begin
        case (awAddr)
          // an instruction write answers only after its push
          ADDR_INSTR: pushValid <= 1'b1;
          ADDR_A, ADDR_B, ADDR_IMM: begin
            bValid <= 1'b1;
            bResp  <= gambitExecPkg::OKAY;
          end
          default: begin
            bValid <= 1'b1;
            bResp  <= gambitExecPkg::SLVERR;
          end
        endcase
      end
      if (pushValid && pushReady) begin
        pushValid <= 1'b0;
        bValid    <= 1'b1;
        bResp     <= gambitExecPkg::OKAY;
      end
      // accept never fires while bValid is high, so no clash here
      if (bValid && bReady)
        bValid <= 1'b0;
    end
  end

endmodule

// ==== rtl/gambitIssueQueue.sv ====
/* gambit issue queue
   in-order FIFO of issue entries with valid/ready on push and pop */
`timescale 1ns/1ps
`include "gambit_cfg.svh"

module gambitIssueQueue (
  input  logic                        clk,
  input  logic                        arstN,
  input  logic                        pushValid,
  input  gambitExecPkg::issueEntryT   pushEntry,
  input  logic                        popReady,
  output logic                        pushReady,
  output logic                        popValid,
  output gambitExecPkg::issueEntryT   popEntry
);

  localparam int AW = $clog2(`GAMBIT_QDEPTH);

  gambitExecPkg::issueEntryT mem [`GAMBIT_QDEPTH];
  // the extra top bit tells a full buffer from an empty one
  logic [AW:0] wrPtr;
  logic [AW:0] rdPtr;
  logic        full;
  logic        empty;

  assign empty = wrPtr == rdPtr;
  assign full  = (wrPtr[AW] != rdPtr[AW]) && (wrPtr[AW-1:0] == rdPtr[AW-1:0]);

  assign pushReady = ~full;
  assign popValid  = ~empty;
  assign popEntry  = mem[rdPtr[AW-1:0]];

  always_ff @(posedge clk) begin
    if (pushValid && pushReady)
      mem[wrPtr[AW-1:0]] <= pushEntry;
  end

  // push and pop may both happen in one cycle
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
    end else begin
      if (pushValid && pushReady)
        wrPtr <= wrPtr + 1'b1;
      if (popValid && popReady)
        rdPtr <= rdPtr + 1'b1;
    end
  end

endmodule

// ==== rtl/gambitExecute.sv ====
/* gambit execute stage
   pops issue entries, runs the ALU and returns results on the AXI4-Lite read channel */
`timescale 1ns/1ps
`include "gambit_cfg.svh"

module gambitExecute (
  input  logic                        clk,
  input  logic                        arstN,
  input  logic                        popValid,
  input  gambitExecPkg::issueEntryT   popEntry,
  input  logic [`GAMBIT_WID-1:0]      csrValue,
  input  logic                        arValid,
  input  logic [`GAMBIT_AXI_AW-1:0]   arAddr,
  input  logic                        rReady,
  output logic                        popReady,
  output logic                        arReady,
  output logic                        rValid,
  output logic [`GAMBIT_AXI_DW-1:0]   rData,
  output gambitExecPkg::respT         rResp
);

  logic [`GAMBIT_WID-1:0] aluResult;
  logic [`GAMBIT_WID-1:0] resultReg;
  // set while resultReg holds a result that has not been read out
  logic                   resValid;

  gambitAlu gambitAlu_i (
    .instr    (popEntry.instr),
    .a        (popEntry.a),
    .b        (popEntry.b),
    .imm      (popEntry.imm),
    .csrValue (csrValue),
    .result   (aluResult)
  );

  // an unread result blocks the next pop, which backs up the queue
  assign popReady = ~resValid;

  // reads are not decoded, so any address gets the held result
  assign arReady = resValid & ~rValid;

  assign rData = {{(`GAMBIT_AXI_DW - `GAMBIT_WID){1'b0}}, resultReg};
  assign rResp = gambitExecPkg::OKAY;

  // ==============================
  // result register
  // ==============================
  // resultReg only loads while resValid is low, so rData holds still
  // for as long as rValid waits on rReady
  always_ff @(posedge clk) begin
    if (popValid && popReady)
      resultReg <= aluResult;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      resValid <= 1'b0;
      rValid   <= 1'b0;
    end else begin
      if (popValid && popReady)
        resValid <= 1'b1;
      if (arValid && arReady)
        rValid <= 1'b1;
      // the register frees up once the read response has gone out
      if (rValid && rReady) begin
        rValid   <= 1'b0;
        resValid <= 1'b0;
      end
    end
  end

endmodule

// ==== rtl/gambitExecUnit.sv ====
/* gambit execute unit top level
   AXI4-Lite issue stage, in-order queue and execute stage */
`timescale 1ns/1ps
`include "gambit_cfg.svh"

module gambitExecUnit (
  input  logic                        clk,
  input  logic                        arstN,
  input  logic [`GAMBIT_WID-1:0]      csrValue,
  // write channel
  input  logic                        awValid,
  output logic                        awReady,
  input  logic [`GAMBIT_AXI_AW-1:0]   awAddr,
  input  logic                        wValid,
  output logic                        wReady,
  input  logic [`GAMBIT_AXI_DW-1:0]   wData,
  output logic                        bValid,
  input  logic                        bReady,
  output gambitExecPkg::respT         bResp,
  // read channel
  input  logic                        arValid,
  output logic                        arReady,
  input  logic [`GAMBIT_AXI_AW-1:0]   arAddr,
  output logic                        rValid,
  input  logic                        rReady,
  output logic [`GAMBIT_AXI_DW-1:0]   rData,
  output gambitExecPkg::respT         rResp
);

  logic                       pushValid;
  logic                       pushReady;
  gambitExecPkg::issueEntryT  pushEntry;
  logic                       popValid;
  logic                       popReady;
  gambitExecPkg::issueEntryT  popEntry;

  gambitIssue gambitIssue_i (
    .clk       (clk),
    .arstN     (arstN),
    .awValid   (awValid),
    .awAddr    (awAddr),
    .wValid    (wValid),
    .wData     (wData),
    .bReady    (bReady),
    .pushReady (pushReady),
    .awReady   (awReady),
    .wReady    (wReady),
    .bValid    (bValid),
    .bResp     (bResp),
    .pushValid (pushValid),
    .pushEntry (pushEntry)
  );

  gambitIssueQueue gambitIssueQueue_i (
    .clk       (clk),
    .arstN     (arstN),
    .pushValid (pushValid),
    .pushEntry (pushEntry),
    .popReady  (popReady),
    .pushReady (pushReady),
    .popValid  (popValid),
    .popEntry  (popEntry)
  );

  gambitExecute gambitExecute_i (
    .clk      (clk),
    .arstN    (arstN),
    .popValid (popValid),
    .popEntry (popEntry),
    .csrValue (csrValue),
    .arValid  (arValid),
    .arAddr   (arAddr),
    .rReady   (rReady),
    .popReady (popReady),
    .arReady  (arReady),
    .rValid   (rValid),
    .rData    (rData),
    .rResp    (rResp)
  );

endmodule

// ==== verif/gambitExecUnit_sva.sv ====
/* AXI4-Lite protocol checks on the execute unit host port
   bound to the top level */
`timescale 1ns/1ps
`include "gambit_cfg.svh"

module gambitExecUnit_sva (
  input logic                       clk,
  input logic                       arstN,
  input logic                       awReady,
  input logic                       wReady,
  input logic                       bValid,
  input logic                       bReady,
  input logic                       rValid,
  input logic                       rReady,
  input logic [`GAMBIT_AXI_DW-1:0]  rData
);

  // ==============================
  // handshake rules
  // ==============================
  // a write response stays up until the host takes it
  bHold: assert property (@(posedge clk) disable iff (!arstN)
    bValid && !bReady |=> bValid)
    else $error("bValid dropped before bReady");

  // the same for the read response, whose data must not move meanwhile
  rHold: assert property (@(posedge clk) disable iff (!arstN)
    rValid && !rReady |=> rValid)
    else $error("rValid dropped before rReady");

  rStable: assert property (@(posedge clk) disable iff (!arstN)
    rValid && !rReady |=> $stable(rData))
    else $error("rData changed while waiting for rReady");

  // address and data are always accepted together
  readyPair: assert property (@(posedge clk) awReady == wReady)
    else $error("awReady and wReady differ");

  // nothing is offered to the host while reset is held
  resetQuiet: assert property (@(posedge clk) !arstN |-> !bValid && !rValid)
    else $error("valid output high during reset");

endmodule

bind gambitExecUnit gambitExecUnit_sva gambitExecUnit_sva_i (
  .clk     (clk),
  .arstN   (arstN),
  .awReady (awReady),
  .wReady  (wReady),
  .bValid  (bValid),
  .bReady  (bReady),
  .rValid  (rValid),
  .rReady  (rReady),
  .rData   (rData)
);

// ==== verif/gambitExecUnit_tb.sv ====
/* gambit execute unit testbench
   issues ALU patterns over AXI4-Lite and checks the results read back */
`timescale 1ns/1ps
`include "gambit_cfg.svh"

module gambitExecUnit_tb;

  localparam int WAIT_LIMIT  = 100;
  // writes may sit stalled for a long time while the queue is full
  localparam int STALL_LIMIT = 400;
  localparam int MAX_PAT     = 64;
  localparam int PAD         = `GAMBIT_AXI_DW - `GAMBIT_WID;

  logic                       clk;
  logic                       arstN;
  logic [`GAMBIT_WID-1:0]     csrValue;
  logic                       awValid;
  logic                       awReady;
  logic [`GAMBIT_AXI_AW-1:0]  awAddr;
  logic                       wValid;
  logic                       wReady;
  logic [`GAMBIT_AXI_DW-1:0]  wData;
  logic                       bValid;
  logic                       bReady;
  gambitExecPkg::respT        bResp;
  logic                       arValid;
  logic                       arReady;
  logic [`GAMBIT_AXI_AW-1:0]  arAddr;
  logic                       rValid;
  logic                       rReady;
  logic [`GAMBIT_AXI_DW-1:0]  rData;
  gambitExecPkg::respT        rResp;

  // one entry per line of the pattern file
  logic [5:0]             pOp   [MAX_PAT];
  logic                   pZero [MAX_PAT];
  logic [`GAMBIT_WID-1:0] pA    [MAX_PAT];
  logic [`GAMBIT_WID-1:0] pB    [MAX_PAT];
  logic [`GAMBIT_WID-1:0] pImm  [MAX_PAT];
  logic [`GAMBIT_WID-1:0] pExp  [MAX_PAT];
  int                     numPat;

  int     errors;
  int     tests;
  int     failedTests;
  integer seed;

  gambitExecUnit gambitExecUnit_i (.*);

  always #2 clk = ~clk;

  // ==============================
  // helpers
  // ==============================
  task automatic abortRun(input string what);
    $display("error at %0t: %s", $time, what);
    $display("=== FAIL ===");
    $finish;
  endtask

  task automatic checkResp(input gambitExecPkg::respT got, input gambitExecPkg::respT exp,
                           input string name);
    assert (got == exp) else begin
      $display("mismatch at %0t: %s expected %0d, got %0d", $time, name, exp, got);
      errors = errors + 1;
    end
  endtask

  // inputs change 0.5 ns after a rising edge, outputs are sampled at the falling edge
  task automatic axiWrite(input logic [`GAMBIT_AXI_AW-1:0] addr,
                          input logic [`GAMBIT_AXI_DW-1:0] data, input int limit,
                          output gambitExecPkg::respT resp);
    int n;
    bit done;
    awAddr  = addr;
    wData   = data;
    awValid = 1'b1;
    wValid  = 1'b1;
    n    = 0;
    done = 0;
    while (!done) begin
      @(negedge clk);
      if (awReady && wReady) begin
        done = 1;
      end else begin
        n = n + 1;
        if (n > limit)
          abortRun("write address and data were never accepted");
      end
      @(posedge clk);
      #0.5;
    end
    awValid = 1'b0;
    wValid  = 1'b0;
    n    = 0;
    done = 0;
    // bReady stalls at random to exercise the response hold
    while (!done) begin
      bReady = ($random(seed) % 4) != 0;
      @(negedge clk);
      if (bValid && bReady) begin
        resp = bResp;
        done = 1;
      end else begin
        n = n + 1;
        if (n > limit)
          abortRun("no write response arrived");
      end
      @(posedge clk);
      #0.5;
    end
    bReady = 1'b0;
  endtask

  task automatic axiRead(output logic [`GAMBIT_AXI_DW-1:0] data,
                         output gambitExecPkg::respT resp);
    int n;
    int delay;
    bit done;
    delay = $unsigned($random(seed)) % 4;
    repeat (delay) begin
      @(posedge clk);
      #0.5;
    end
    arAddr  = `GAMBIT_AXI_AW'h00;
    arValid = 1'b1;
    n    = 0;
    done = 0;
    while (!done) begin
      @(negedge clk);
      if (arReady) begin
        done = 1;
      end else begin
        n = n + 1;
        if (n > STALL_LIMIT)
          abortRun("read address was never accepted");
      end
      @(posedge clk);
      #0.5;
    end
    arValid = 1'b0;
    n    = 0;
    done = 0;
    while (!done) begin
      rReady = ($random(seed) % 4) != 0;
      @(negedge clk);
      if (rValid && rReady) begin
        data = rData;
        resp = rResp;
        done = 1;
      end else begin
        n = n + 1;
        if (n > WAIT_LIMIT)
          abortRun("no read data arrived");
      end
      @(posedge clk);
      #0.5;
    end
    rReady = 1'b0;
  endtask

  // stage A, B and the immediate, then the instruction word issues
  task automatic issueOp(input int k, input int limit);
    gambitExecPkg::respT resp;
    axiWrite(`GAMBIT_AXI_AW'h00, {{PAD{1'b0}}, pA[k]}, limit, resp);
    checkResp(resp, gambitExecPkg::OKAY, "bResp");
    axiWrite(`GAMBIT_AXI_AW'h08, {{PAD{1'b0}}, pB[k]}, limit, resp);
    checkResp(resp, gambitExecPkg::OKAY, "bResp");
    axiWrite(`GAMBIT_AXI_AW'h10, {{PAD{1'b0}}, pImm[k]}, limit, resp);
    checkResp(resp, gambitExecPkg::OKAY, "bResp");
    // the CSR patterns expect the B column back as the CSR value
    csrValue = pB[k];
    axiWrite(`GAMBIT_AXI_AW'h18, {{(`GAMBIT_AXI_DW - 7){1'b0}}, pZero[k], pOp[k]},
             limit, resp);
    checkResp(resp, gambitExecPkg::OKAY, "bResp");
  endtask

  task automatic readCheck(input int k);
    logic [`GAMBIT_AXI_DW-1:0] got;
    gambitExecPkg::respT       resp;
    axiRead(got, resp);
    assert (got == {{PAD{1'b0}}, pExp[k]}) else begin
      $display("mismatch at %0t: rData expected %h, got %h", $time,
               {{PAD{1'b0}}, pExp[k]}, got);
      errors = errors + 1;
    end
    checkResp(resp, gambitExecPkg::OKAY, "rResp");
  endtask

  task automatic reportTest(input string name, input int errBefore);
    tests = tests + 1;
    if (errors == errBefore) begin
      $display("test %s: ok", name);
    end else begin
      failedTests = failedTests + 1;
      $display("test %s: failed", name);
    end
  endtask

  // lines starting with # describe the columns and are skipped
  task automatic loadPatterns();
    int    fd;
    int    rc;
    string line;
    numPat = 0;
    fd = $fopen("verif/alu_patterns.txt", "r");
    if (fd == 0) begin
      abortRun("cannot open verif/alu_patterns.txt");
    end else begin
      while (!$feof(fd) && numPat < MAX_PAT) begin
        line = "";
        rc = $fgets(line, fd);
        if (line.len() > 1 && line.getc(0) != "#") begin
          rc = $sscanf(line, "%h %h %h %h %h %h", pOp[numPat], pZero[numPat],
                       pA[numPat], pB[numPat], pImm[numPat], pExp[numPat]);
          if (rc == 6)
            numPat = numPat + 1;
        end
      end
      $fclose(fd);
      if (numPat < 6)
        abortRun("pattern file holds fewer than six operations");
    end
  endtask

  // ==============================
  // test sequence
  // ==============================
  initial begin
    int                  k;
    int                  wj;
    int                  rj;
    int                  n;
    int                  stallRun;
    int                  errBefore;
    gambitExecPkg::respT resp;
    seed        = 32'h6843_304b;
    errors      = 0;
    tests       = 0;
    failedTests = 0;
    clk         = 1'b0;
    arstN       = 1'b1;
    csrValue    = '0;
    awValid     = 1'b0;
    awAddr      = '0;
    wValid      = 1'b0;
    wData       = '0;
    bReady      = 1'b0;
    arValid     = 1'b0;
    arAddr      = '0;
    rReady      = 1'b0;
    loadPatterns();

    // a clean falling edge on arstN, then four clock cycles in reset
    #1 arstN = 1'b0;
    repeat (4) @(posedge clk);
    #0.5;
    arstN = 1'b1;
    @(posedge clk);
    #0.5;

    // each pattern is issued and read back on its own
    for (k = 0; k < numPat; k++) begin
      errBefore = errors;
      issueOp(k, WAIT_LIMIT);
      readCheck(k);
      reportTest($sformatf("pattern %0d opcode %h", k, pOp[k]), errBefore);
    end

    // five operations fill the result register and the queue
    // so the sixth stalls until the reader frees a slot
    errBefore = errors;
    fork
      begin
        for (wj = 0; wj < 6; wj++)
          issueOp(wj, STALL_LIMIT);
      end
      begin
        stallRun = 0;
        n        = 0;
        while (stallRun < 10) begin
          @(negedge clk);
          if (awValid && !awReady)
            stallRun = stallRun + 1;
          else
            stallRun = 0;
          n = n + 1;
          if (n > STALL_LIMIT)
            abortRun("writes never stalled under back-pressure");
          @(posedge clk);
          #0.5;
        end
        for (rj = 0; rj < 6; rj++)
          readCheck(rj);
      end
    join
    reportTest("back-pressure in issue order", errBefore);

    // an unmapped address is refused and must not create a result
    errBefore = errors;
    axiWrite(`GAMBIT_AXI_AW'h20, 64'h0123_4567_89ab_cdef, WAIT_LIMIT, resp);
    checkResp(resp, gambitExecPkg::SLVERR, "bResp");
    repeat (10) begin
      @(negedge clk);
      assert (!arReady && !rValid) else begin
        $display("a result appeared for the unmapped write at %0t", $time);
        errors = errors + 1;
      end
      @(posedge clk);
      #0.5;
    end
    issueOp(0, WAIT_LIMIT);
    readCheck(0);
    reportTest("unmapped write address", errBefore);

    $display("%0d tests, %0d passed, %0d failed, %0d errors", tests,
             tests - failedTests, failedTests, errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

// ==== verif/alu_patterns.txt ====
# columns: opcode zero a b imm expected, all in hex
# zero=1 makes a register-register form use imm for b, csr returns the b column
04 0 0000000000123 0000000000456 0000000000000 0000000000579
04 1 0000000000100 0000000000999 0000000000001 0000000000101
05 0 0000000000005 0000000000007 0000000000000 FFFFFFFFFFFFE
08 0 00000000FF0F0 00000000F0F0F 0000000000000 00000000F0000
09 0 00000000FF0F0 00000000F0F0F 0000000000000 00000000FFFFF
0A 0 00000000FF0F0 00000000F0F0F 0000000000000 000000000FFFF
06 0 FFFFFFFFFFFFF 0000000000001 0000000000000 0000000000003
07 0 FFFFFFFFFFFFF 0000000000001 0000000000000 0000000000001
16 0 0000000000042 0000000000000 0000000000042 0000000000000
17 0 0000000000001 0000000000000 FFFFFFFFFFFFF 0000000000003
0C 0 0000000000001 0000000000000 0000000000000 0000000000001
0C 0 0000000000001 0000000000033 0000000000000 8000000000000
0C 0 0000000000001 0000000000034 0000000000000 0000000000000
0D 0 8000000000000 0000000000033 0000000000000 FFFFFFFFFFFFF
0D 0 8000000000000 000000000003F 0000000000000 FFFFFFFFFFFFF
0D 1 4000000000000 0000000000000 0000000000004 0400000000000
0E 0 8000000000000 0000000000033 0000000000000 0000000000001
0E 0 8000000000000 000000000003F 0000000000000 0000000000000
10 0 8000000000001 0000000000001 0000000000000 0000000000003
10 0 8000000000001 0000000000034 0000000000000 8000000000001
11 0 0000000000001 0000000000033 0000000000000 0000000000002
11 0 0000000000003 000000000003F 0000000000000 0060000000000
14 0 FFFFFFFFFFFFF 0000000000000 0000000000002 0000000000001
15 0 0000000000010 0000000000001 0000000000003 000000000000D
18 0 0000000ABCDEF 0000000000000 00000000FFF00 00000000BCD00
19 0 0000000000F00 0000000000000 00000000000FF 0000000000FFF
1A 0 FFFFFFFFFFFFF 0000000000000 0000000000FFF FFFFFFFFFF000
20 0 0000000000000 0000000C5C5C5 0000000000000 0000000C5C5C5
20 0 0000000000000 ABCDE12345678 0000000000000 ABCDE12345678
3F 0 0000000000001 0000000000002 0000000000000 0DEAEDEAEDEAE

// ==== vlog.f ====
+incdir+include
rtl/gambitIsaPkg.sv
rtl/gambitExecPkg.sv
rtl/gambitAlu.sv
rtl/gambitIssue.sv
rtl/gambitIssueQueue.sv
rtl/gambitExecute.sv
rtl/gambitExecUnit.sv
verif/gambitExecUnit_sva.sv
verif/gambitExecUnit_tb.sv

// ==== Makefile ====
# Verilator build and run of the gambit execute unit testbench

VERILATOR ?= verilator
TOP       ?= gambitExecUnit_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
